// ==== rtl/board_pin_pkg.sv ====
// Board pin layout definitions.
// Covers the open-drain I2C buses, the pin loopback vector and the
// idle level of undriven board lines.
package board_pin_pkg;

  // Open-drain I2C buses with a device attached.
  // Bus 0 is the HAT ID EEPROM bus.
  // Bus 1 is the HAT secondary bus, shared with GPIO2/3.
  // Bus 2 is the QWIIC1 connector.
  localparam int unsigned NumI2cBuses = 3;

  // Number of pins looped back from an output to an input.
  localparam int unsigned LoopbackWidth = 5;

  // Bit positions in the loopback vector.
  // mikroBUS COPI returning on CIPO.
  localparam int unsigned LbSpi   = 0;
  // mikroBUS UART TX returning on RX.
  localparam int unsigned LbUart  = 1;
  // mikroBUS PWM returning on PMOD0.1.
  localparam int unsigned LbPwm   = 2;
  // Arduino GPIO1 returning on GPIO0.
  localparam int unsigned LbGpio0 = 3;
  // Arduino GPIO8 returning on GPIO9.
  localparam int unsigned LbGpio1 = 4;

  // Level of a released line.
  // Pull-ups hold open-drain and RS-485 lines high when nobody drives.
  localparam logic LineIdle = 1'b1;

endpackage

// ==== rtl/cheri_err_pkg.sv ====
// CHERI capability error layout.
// Width of the error vector and the meaning of each error line.
package cheri_err_pkg;

  // One line per capability check.
  localparam int unsigned CheriErrWidth = 9;

  // Bits needed to name one error line.
  localparam int unsigned CheriIdxWidth = $clog2(CheriErrWidth);

  // Index of one error line.
  typedef logic [CheriIdxWidth-1:0] cheri_err_idx_t;

  // Position of each error kind in the error vector.
  // Access outside the capability bounds.
  localparam cheri_err_idx_t ErrBounds              = 4'd0;
  // Use of an untagged capability.
  localparam cheri_err_idx_t ErrTag                 = 4'd1;
  // Use of a sealed capability.
  localparam cheri_err_idx_t ErrSeal                = 4'd2;
  // Missing execute permission.
  localparam cheri_err_idx_t ErrPermitExecute       = 4'd3;
  // Missing load permission.
  localparam cheri_err_idx_t ErrPermitLoad          = 4'd4;
  // Missing store permission.
  localparam cheri_err_idx_t ErrPermitStore         = 4'd5;
  // Missing capability store permission.
  localparam cheri_err_idx_t ErrPermitStoreCap      = 4'd6;
  // Missing local capability store permission.
  localparam cheri_err_idx_t ErrPermitStoreLocalCap = 4'd7;
  // Missing system register access permission.
  localparam cheri_err_idx_t ErrPermitAccSysRegs    = 4'd8;

endpackage

// ==== rtl/i2c_bus_resolve.sv ====
// I2C open-drain bus resolution.
// Combines the controller drive and the device pull-down of each bus into
// the level seen on the wire, which also feeds back to the controller.
module i2c_bus_resolve (
  // Controller side, per bus.
  input  logic [board_pin_pkg::NumI2cBuses-1:0] scl_o_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0] scl_oe_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0] sda_o_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0] sda_oe_i,
  // Device side, low means pulling the line down.
  input  logic [board_pin_pkg::NumI2cBuses-1:0] scl_dev_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0] sda_dev_i,
  // Resolved line levels.
  output logic [board_pin_pkg::NumI2cBuses-1:0] scl_line_o,
  output logic [board_pin_pkg::NumI2cBuses-1:0] sda_line_o
);
  import board_pin_pkg::*;

  // Level the controller puts on each line.
  logic [NumI2cBuses-1:0] scl_drv;
  logic [NumI2cBuses-1:0] sda_drv;

  // A controller with its enable clear releases the line.
  // The pull-up then holds it at the idle level.
  always_comb begin
    for (int unsigned b = 0; b < NumI2cBuses; b++) begin
      scl_drv[b] = scl_oe_i[b] ? scl_o_i[b] : LineIdle;
      sda_drv[b] = sda_oe_i[b] ? sda_o_i[b] : LineIdle;
    end
  end

  // Wired-AND of both ends of the bus.
  // The line carries outbound and inbound traffic together.
  // The controller reads back its own bits, so it sees no false contention.
  assign scl_line_o = scl_drv & scl_dev_i;
  assign sda_line_o = sda_drv & sda_dev_i;

  // A controller pulling low always wins over the pull-up and the device.
  always_comb begin
    assert final (((scl_oe_i & ~scl_o_i) & scl_line_o) == '0)
      else $error("SCL line high while its controller drives low");
    assert final (((sda_oe_i & ~sda_o_i) & sda_line_o) == '0)
      else $error("SDA line high while its controller drives low");
  end

endmodule

// ==== rtl/pin_loopback.sv ====
// Pin loopback retiming.
// Returns each looped-back output pin to its input pin through one
// register stage, so the harness never closes a combinational loop.
module pin_loopback (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Pins driven by the system.
  input  logic [board_pin_pkg::LoopbackWidth-1:0] lb_out_i,
  // Pins read back by the system.
  output logic [board_pin_pkg::LoopbackWidth-1:0] lb_in_o
);
  import board_pin_pkg::*;

  // Map of the loopback vector.
  // Bit LbSpi returns mikroBUS COPI on CIPO for the SPI loopback.
  // Bit LbUart returns mikroBUS TX on RX for the UART loopback.
  // Bit LbPwm returns mikroBUS PWM on PMOD0.1.
  // Bit LbGpio0 returns Arduino GPIO1 on GPIO0.
  // Bit LbGpio1 returns Arduino GPIO8 on GPIO9.
  // Positions come from board_pin_pkg.

  // Retiming stage.
  logic [LoopbackWidth-1:0] loopback_q;

  // The pinmux sees whole pin vectors, not single bits.
  // Without this stage an output bit and its input bit would look like
  // a loop through the pinmux, even though no bit feeds itself.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Inputs read low until the first edge after reset.
      loopback_q <= '0;
    end else begin
      // Every pin is sampled on the same edge.
      loopback_q <= lb_out_i;
    end
  end

  // One cycle from an output pin to its input pin.
  assign lb_in_o = loopback_q;

endmodule

// ==== rtl/cheri_err_monitor.sv ====
// CHERI capability error monitor.
// Keeps a sticky record of every error line ever raised and emits a
// one-cycle report with the lowest index on each first occurrence.
module cheri_err_monitor (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Error lines, modulated for board LEDs.
  input  logic [cheri_err_pkg::CheriErrWidth-1:0] cheri_err_i,
  // Sticky record of raised errors.
  output logic [cheri_err_pkg::CheriErrWidth-1:0] cheri_errored_o,
  // Pulse on a first occurrence.
  output logic                                    cheri_new_o,
  // Lowest newly raised error line.
  output cheri_err_pkg::cheri_err_idx_t           cheri_new_idx_o
);
  import cheri_err_pkg::*;

  logic [CheriErrWidth-1:0] errored_q;
  logic [CheriErrWidth-1:0] new_err;
  logic                     any_new;
  logic                     new_q;
  cheri_err_idx_t           new_idx_d;
  cheri_err_idx_t           new_idx_q;

  // Lines raised now that were never raised before.
  // The error lines blink, so repeats of a recorded line are filtered here.
  assign new_err = cheri_err_i & ~errored_q;
  assign any_new = |new_err;

  // Priority search over the new lines.
  // Scanning downwards leaves the lowest set index last.
  always_comb begin
    new_idx_d = '0;
    for (int i = CheriErrWidth - 1; i >= 0; i--) begin
      if (new_err[i]) begin
        new_idx_d = cheri_err_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errored_q <= '0;
      new_q     <= 1'b0;
      new_idx_q <= '0;
    end else begin
      // Pulse only on edges that add to the record.
      new_q <= any_new;
      if (any_new) begin
        // Record every line that is high, old or new.
        errored_q <= errored_q | cheri_err_i;
        new_idx_q <= new_idx_d;
      end
    end
  end

  assign cheri_errored_o = errored_q;
  assign cheri_new_o     = new_q;
  // Index holds its last value between pulses.
  assign cheri_new_idx_o = new_idx_q;

  // The record only grows until the next reset.
  a_record_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(cheri_errored_o) & ~cheri_errored_o) == '0)
    else $error("CHERI error record lost a bit");

  // Back-to-back pulses need the record to grow on both edges.
  a_pulse_grows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_new_o && $past(cheri_new_o) |->
      (cheri_errored_o != $past(cheri_errored_o)) &&
      ($past(cheri_errored_o) != $past(cheri_errored_o, 2)))
    else $error("CHERI report pulsed without a new error");

  // A reported index names a real error line that is now recorded.
  a_idx_recorded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_new_o |-> (cheri_new_idx_o <= ErrPermitAccSysRegs) &&
      cheri_errored_o[cheri_new_idx_o])
    else $error("CHERI report index %0d not recorded", cheri_new_idx_o);

endmodule

// ==== rtl/rs485_xcvr.sv ====
// RS-485 half-duplex transceiver.
// Registers the driver and receiver enables and gates the bus lines,
// which idle high while their side is switched off.
module rs485_xcvr (
  input  logic clk_i,
  input  logic rst_ni,
  // System side.
  input  logic tx_i,
  input  logic tx_enable_i,
  input  logic rx_enable_i,
  // Receiver output from the remote side.
  input  logic ro_line_i,
  // Transceiver pins.
  output logic di_o,
  output logic de_o,
  output logic ren_o,
  // Bus level seen by the remote side.
  output logic tx_line_o,
  // Received data to the system.
  output logic rx_o
);
  import board_pin_pkg::*;

  // Driver enable, active high.
  logic de_q;
  // Receiver disable, active high.
  logic ren_q;

  // Direction controls change one cycle after the request.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Driver off the bus and receiver disabled.
      de_q  <= 1'b0;
      ren_q <= 1'b1;
    end else begin
      de_q  <= tx_enable_i;
      ren_q <= ~rx_enable_i;
    end
  end

  assign de_o  = de_q;
  assign ren_o = ren_q;

  // Driver input follows transmit data directly.
  assign di_o = tx_i;

  // The driver reaches the bus only while enabled.
  // Otherwise the bias network holds the line idle.
  assign tx_line_o = de_q ? di_o : LineIdle;

  // A disabled receiver leaves the UART input idle.
  assign rx_o = ren_q ? LineIdle : ro_line_i;

  // Driver and receiver on together only if both were requested.
  a_dir_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    de_o && !ren_o |-> $past(tx_enable_i && rx_enable_i))
    else $error("RS-485 driver and receiver both on without request");

endmodule

// ==== rtl/board_top.sv ====
// Board pin harness top level.
// Joins I2C bus resolution, pin loopbacks, the CHERI error monitor and
// the RS-485 transceiver under one set of board ports.
module board_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // I2C controller side.
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   scl_o_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   scl_oe_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   sda_o_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   sda_oe_i,
  // I2C device side.
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   scl_dev_i,
  input  logic [board_pin_pkg::NumI2cBuses-1:0]   sda_dev_i,
  // Resolved I2C lines.
  output logic [board_pin_pkg::NumI2cBuses-1:0]   scl_line_o,
  output logic [board_pin_pkg::NumI2cBuses-1:0]   sda_line_o,
  // Pin loopbacks.
  input  logic [board_pin_pkg::LoopbackWidth-1:0] lb_out_i,
  output logic [board_pin_pkg::LoopbackWidth-1:0] lb_in_o,
  // CHERI error reporting.
  input  logic [cheri_err_pkg::CheriErrWidth-1:0] cheri_err_i,
  output logic [cheri_err_pkg::CheriErrWidth-1:0] cheri_errored_o,
  output logic                                    cheri_new_o,
  output cheri_err_pkg::cheri_err_idx_t           cheri_new_idx_o,
  // RS-485 system side.
  input  logic                                    rs485_tx_i,
  input  logic                                    rs485_tx_enable_i,
  input  logic                                    rs485_rx_enable_i,
  output logic                                    rs485_rx_o,
  // RS-485 transceiver and bus side.
  input  logic                                    rs485_ro_line_i,
  output logic                                    rs485_di_o,
  output logic                                    rs485_de_o,
  output logic                                    rs485_ren_o,
  output logic                                    rs485_tx_line_o
);

  // Open-drain buses, purely combinational.
  i2c_bus_resolve u_i2c_bus_resolve (
    .scl_o_i    (scl_o_i),
    .scl_oe_i   (scl_oe_i),
    .sda_o_i    (sda_o_i),
    .sda_oe_i   (sda_oe_i),
    .scl_dev_i  (scl_dev_i),
    .sda_dev_i  (sda_dev_i),
    .scl_line_o (scl_line_o),
    .sda_line_o (sda_line_o)
  );

  // Loopback pins, one cycle.
  pin_loopback u_pin_loopback (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .lb_out_i (lb_out_i),
    .lb_in_o  (lb_in_o)
  );

  // Sticky error record and first-occurrence report.
  cheri_err_monitor u_cheri_err_monitor (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cheri_err_i     (cheri_err_i),
    .cheri_errored_o (cheri_errored_o),
    .cheri_new_o     (cheri_new_o),
    .cheri_new_idx_o (cheri_new_idx_o)
  );

  // Half-duplex serial transceiver.
  rs485_xcvr u_rs485_xcvr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tx_i        (rs485_tx_i),
    .tx_enable_i (rs485_tx_enable_i),
    .rx_enable_i (rs485_rx_enable_i),
    .ro_line_i   (rs485_ro_line_i),
    .di_o        (rs485_di_o),
    .de_o        (rs485_de_o),
    .ren_o       (rs485_ren_o),
    .tx_line_o   (rs485_tx_line_o),
    .rx_o        (rs485_rx_o)
  );

endmodule

// ==== sim/board_top_tb.sv ====
// Testbench for the board pin harness.
// Drives random pin, error and RS-485 traffic into the DUT while
// concurrent assertions compare every output against reference models.
module board_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import board_pin_pkg::*;
  import cheri_err_pkg::*;

  localparam int MaxCycles = 2000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic [NumI2cBuses-1:0] ctrl_scl;
  logic [NumI2cBuses-1:0] ctrl_scl_oe;
  logic [NumI2cBuses-1:0] ctrl_sda;
  logic [NumI2cBuses-1:0] ctrl_sda_oe;
  logic [NumI2cBuses-1:0] dev_scl;
  logic [NumI2cBuses-1:0] dev_sda;
  logic [NumI2cBuses-1:0] scl_line;
  logic [NumI2cBuses-1:0] sda_line;
  logic [NumI2cBuses-1:0] scl_exp;
  logic [NumI2cBuses-1:0] sda_exp;
  logic [LoopbackWidth-1:0] lb_out;
  logic [LoopbackWidth-1:0] lb_in;
  logic [LoopbackWidth-1:0] lb_exp = '0;
  logic [CheriErrWidth-1:0] cheri_err;
  logic [CheriErrWidth-1:0] cheri_errored;
  logic cheri_new;
  cheri_err_idx_t cheri_new_idx;
  logic rs485_tx;
  logic rs485_tx_enable;
  logic rs485_rx_enable;
  logic rs485_ro_line;
  logic rs485_rx;
  logic rs485_di;
  logic rs485_de;
  logic rs485_ren;
  logic rs485_tx_line;
  logic de_exp = 1'b0;
  logic ren_exp = 1'b1;
  logic tx_line_exp;
  logic rx_exp;
  // CHERI expectations are staged with the pattern and move on one edge later.
  logic stage_new = 1'b0;
  cheri_err_idx_t stage_idx = '0;
  logic [CheriErrWidth-1:0] stage_errored = '0;
  logic new_exp = 1'b0;
  cheri_err_idx_t idx_exp = '0;
  logic [CheriErrWidth-1:0] errored_exp = '0;
  // Per-test enables for the checks.
  logic reset_active = 1'b0;
  logic i2c_active = 1'b0;
  logic lb_active = 1'b0;
  logic cheri_active = 1'b0;
  logic tx_active = 1'b0;
  logic rx_active = 1'b0;
  // Loopback, record, pulse, de, ren, tx line and rx line.
  logic [LoopbackWidth+CheriErrWidth+4:0] reset_obs;
  logic [LoopbackWidth+CheriErrWidth+4:0] reset_exp;
  integer seed = 32'h4c80;
  int error_count = 0;
  int test_count = 0;
  int cycle_count = 0;

  board_top u_board_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_o_i           (ctrl_scl),
    .scl_oe_i          (ctrl_scl_oe),
    .sda_o_i           (ctrl_sda),
    .sda_oe_i          (ctrl_sda_oe),
    .scl_dev_i         (dev_scl),
    .sda_dev_i         (dev_sda),
    .scl_line_o        (scl_line),
    .sda_line_o        (sda_line),
    .lb_out_i          (lb_out),
    .lb_in_o           (lb_in),
    .cheri_err_i       (cheri_err),
    .cheri_errored_o   (cheri_errored),
    .cheri_new_o       (cheri_new),
    .cheri_new_idx_o   (cheri_new_idx),
    .rs485_tx_i        (rs485_tx),
    .rs485_tx_enable_i (rs485_tx_enable),
    .rs485_rx_enable_i (rs485_rx_enable),
    .rs485_rx_o        (rs485_rx),
    .rs485_ro_line_i   (rs485_ro_line),
    .rs485_di_o        (rs485_di),
    .rs485_de_o        (rs485_de),
    .rs485_ren_o       (rs485_ren),
    .rs485_tx_line_o   (rs485_tx_line)
  );

  always #4 clk_i = ~clk_i;

  // A released controller reads as high before the AND with the device.
  function automatic logic [NumI2cBuses-1:0] wired_and(
    input logic [NumI2cBuses-1:0] drv, input logic [NumI2cBuses-1:0] oe,
    input logic [NumI2cBuses-1:0] dev);
    return ((drv & oe) | ~oe) & dev;
  endfunction

  // Short label for each error kind.
  function automatic string err_name(input cheri_err_idx_t idx);
    case (idx)
      ErrBounds:              return "bounds";
      ErrTag:                 return "tag";
      ErrSeal:                return "seal";
      ErrPermitExecute:       return "permit_execute";
      ErrPermitLoad:          return "permit_load";
      ErrPermitStore:         return "permit_store";
      ErrPermitStoreCap:      return "permit_store_cap";
      ErrPermitStoreLocalCap: return "permit_store_local_cap";
      ErrPermitAccSysRegs:    return "permit_acc_sys_regs";
      default:                return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - errs_before);
  endtask

  // Reference models.
  // Each register holds what the DUT should show one edge later.
  assign scl_exp = wired_and(ctrl_scl, ctrl_scl_oe, dev_scl);
  assign sda_exp = wired_and(ctrl_sda, ctrl_sda_oe, dev_sda);
  assign tx_line_exp = de_exp ? rs485_tx : 1'b1;
  assign rx_exp = ren_exp ? 1'b1 : rs485_ro_line;
  assign reset_obs = {lb_in, cheri_errored, cheri_new, rs485_de, rs485_ren,
                      rs485_tx_line, rs485_rx};
  // After reset all is quiet, driver and receiver are off and both lines idle high.
  assign reset_exp = {{LoopbackWidth{1'b0}}, {CheriErrWidth{1'b0}}, 5'b00111};

  always @(posedge clk_i) begin
    lb_exp <= lb_out;
    de_exp <= rs485_tx_enable;
    ren_exp <= ~rs485_rx_enable;
    new_exp <= stage_new;
    idx_exp <= stage_idx;
    errored_exp <= stage_errored;
  end

  a_reset_state: assert property (@(posedge clk_i) reset_active |-> reset_obs == reset_exp)
    else report_mismatch("reset_state", $sampled(reset_exp), $sampled(reset_obs));
  a_i2c_scl: assert property (@(posedge clk_i) i2c_active |-> scl_line == scl_exp)
    else report_mismatch("i2c_scl", $sampled(scl_exp), $sampled(scl_line));
  a_i2c_sda: assert property (@(posedge clk_i) i2c_active |-> sda_line == sda_exp)
    else report_mismatch("i2c_sda", $sampled(sda_exp), $sampled(sda_line));
  a_loopback: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lb_active |-> lb_in == lb_exp)
    else report_mismatch("loopback", $sampled(lb_exp), $sampled(lb_in));
  a_cheri_new: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_active |-> cheri_new == new_exp)
    else report_mismatch("cheri_new", $sampled(new_exp), $sampled(cheri_new));
  a_cheri_errored: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_active |-> cheri_errored == errored_exp)
    else report_mismatch("cheri_errored", $sampled(errored_exp), $sampled(cheri_errored));
  a_cheri_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_active && new_exp |-> cheri_new_idx == idx_exp)
    else report_mismatch({"cheri_first_", err_name($sampled(idx_exp))},
                         $sampled(idx_exp), $sampled(cheri_new_idx));
  a_tx_de: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_active |-> rs485_de == de_exp)
    else report_mismatch("rs485_de", $sampled(de_exp), $sampled(rs485_de));
  a_tx_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_active |-> rs485_tx_line == tx_line_exp)
    else report_mismatch("rs485_tx_line", $sampled(tx_line_exp), $sampled(rs485_tx_line));
  a_tx_di: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_active |-> rs485_di == rs485_tx)
    else report_mismatch("rs485_di", $sampled(rs485_tx), $sampled(rs485_di));
  a_rx_ren: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_active |-> rs485_ren == ren_exp)
    else report_mismatch("rs485_ren", $sampled(ren_exp), $sampled(rs485_ren));
  a_rx_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_active |-> rs485_rx == rx_exp)
    else report_mismatch("rs485_rx", $sampled(rx_exp), $sampled(rs485_rx));

  // Run limit of about four times what the tests need.
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic test_i2c();
    int errs_before;
    logic [31:0] rnd;
    errs_before = error_count;
    for (int i = 0; i < 100; i++) begin
      @(posedge clk_i);
      i2c_active <= 1'b1;
      rnd = $random(seed);
      ctrl_scl <= rnd[NumI2cBuses-1:0];
      ctrl_scl_oe <= rnd[NumI2cBuses+7:8];
      ctrl_sda <= rnd[NumI2cBuses+15:16];
      ctrl_sda_oe <= rnd[NumI2cBuses+23:24];
      rnd = $random(seed);
      dev_scl <= rnd[NumI2cBuses-1:0];
      dev_sda <= rnd[NumI2cBuses+7:8];
    end
    @(posedge clk_i);
    i2c_active <= 1'b0;
    @(negedge clk_i);
    report_test("i2c_wired_and", errs_before);
  endtask

  task automatic test_loopback();
    int errs_before;
    logic [31:0] rnd;
    errs_before = error_count;
    for (int i = 0; i < 100; i++) begin
      @(posedge clk_i);
      lb_active <= 1'b1;
      rnd = $random(seed);
      lb_out <= rnd[LoopbackWidth-1:0];
    end
    repeat (2) @(posedge clk_i);
    lb_active <= 1'b0;
    @(negedge clk_i);
    report_test("loopback", errs_before);
  endtask

  // Sparse new errors, repeats of recorded ones and quiet gaps take turns.
  task automatic test_cheri();
    int errs_before;
    logic [31:0] rnd;
    logic [CheriErrWidth-1:0] pat;
    logic [CheriErrWidth-1:0] fresh;
    logic [CheriErrWidth-1:0] model;
    cheri_err_idx_t idx;
    logic found;
    errs_before = error_count;
    model = '0;
    for (int i = 0; i < 96; i++) begin
      @(posedge clk_i);
      cheri_active <= 1'b1;
      rnd = $random(seed);
      rnd = rnd & $random(seed) & $random(seed);
      case (i % 3)
        0: pat = rnd[CheriErrWidth-1:0];
        1: pat = model & rnd[CheriErrWidth+7:8];
        default: pat = '0;
      endcase
      fresh = pat & ~model;
      idx = '0;
      found = 1'b0;
      for (int b = 0; b < CheriErrWidth; b++) begin
        if (fresh[b] && !found) begin
          idx = cheri_err_idx_t'(b);
          found = 1'b1;
        end
      end
      model = model | pat;
      cheri_err <= pat;
      stage_new <= found;
      stage_idx <= idx;
      stage_errored <= model;
    end
    repeat (2) @(posedge clk_i);
    cheri_active <= 1'b0;
    @(negedge clk_i);
    report_test("cheri_first_occurrence", errs_before);
  endtask

  task automatic test_rs485(input logic transmit);
    int errs_before;
    logic [31:0] rnd;
    errs_before = error_count;
    for (int i = 0; i < 80; i++) begin
      @(posedge clk_i);
      rnd = $random(seed);
      if (transmit) begin
        tx_active <= 1'b1;
        rs485_tx <= rnd[0];
        rs485_tx_enable <= rnd[4];
      end else begin
        rx_active <= 1'b1;
        rs485_ro_line <= rnd[0];
        rs485_rx_enable <= rnd[4];
      end
    end
    @(posedge clk_i);
    tx_active <= 1'b0;
    rx_active <= 1'b0;
    // Leave both directions off between tests.
    rs485_tx_enable <= 1'b0;
    rs485_rx_enable <= 1'b0;
    @(negedge clk_i);
    report_test(transmit ? "rs485_transmit" : "rs485_receive", errs_before);
  endtask

  initial begin
    ctrl_scl = '0;
    ctrl_scl_oe = '0;
    ctrl_sda = '0;
    ctrl_sda_oe = '0;
    dev_scl = '1;
    dev_sda = '1;
    lb_out = '0;
    cheri_err = '0;
    rs485_tx = 1'b0;
    rs485_tx_enable = 1'b0;
    rs485_rx_enable = 1'b0;
    rs485_ro_line = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_active <= 1'b1;
    @(posedge clk_i);
    reset_active <= 1'b0;
    @(negedge clk_i);
    report_test("reset_state", 0);
    test_i2c();
    test_loopback();
    test_cheri();
    test_rs485(1'b1);
    test_rs485(1'b0);
    $display("tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== board_harness.f ====
rtl/board_pin_pkg.sv
rtl/cheri_err_pkg.sv
rtl/i2c_bus_resolve.sv
rtl/pin_loopback.sv
rtl/cheri_err_monitor.sv
rtl/rs485_xcvr.sv
rtl/board_top.sv
sim/board_top_tb.sv

// ==== Bender.yml ====
package:
  name: board_harness

dependencies: {}

sources:
  # Packages come before the blocks that import them.
  - files:
      - rtl/board_pin_pkg.sv
      - rtl/cheri_err_pkg.sv
  - files:
      - rtl/i2c_bus_resolve.sv
      - rtl/pin_loopback.sv
      - rtl/cheri_err_monitor.sv
      - rtl/rs485_xcvr.sv
      - rtl/board_top.sv
  # Testbench only in simulation.
  - target: test
    files:
      - sim/board_top_tb.sv
